// ==== files.f ====
+incdir+tb
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - hdl/ex_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_mult.sv
      - hdl/ex_writeback.sv
      - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ex_stage.sv

// ==== tb/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the execute stage results
//////////////////////////////////////////////////

// Branch comparison as the instruction set defines it
function automatic logic cmp_ref(input alu_op_e op, input logic [DATA_W-1:0] a,
                                 input logic [DATA_W-1:0] b);
  case (op)
    EQ:      return a == b;
    NE:      return a != b;
    LT:      return $signed(a) < $signed(b);
    GE:      return $signed(a) >= $signed(b);
    LTU:     return a < b;
    GEU:     return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Integer ALU result, compares come back zero-extended
function automatic logic [DATA_W-1:0] alu_ref(input alu_op_e op, input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
  logic [$clog2(DATA_W)-1:0] sh;
  sh = b[$clog2(DATA_W)-1:0];
  case (op)
    ADD:     return a + b;
    SUB:     return a - b;
    XOR:     return a ^ b;
    OR:      return a | b;
    AND:     return a & b;
    SLL:     return a << sh;
    SRL:     return a >> sh;
    SRA:     return $signed(a) >>> sh;
    SLT:     return {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
    SLTU:    return {{(DATA_W-1){1'b0}}, a < b};
    default: return {{(DATA_W-1){1'b0}}, cmp_ref(op, a, b)};
  endcase
endfunction

// Multiply on operands widened to the full product width
function automatic logic [DATA_W-1:0] mult_ref(input mult_op_e op, input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] b);
  logic [2*DATA_W-1:0] a_wide;
  logic [2*DATA_W-1:0] b_wide;
  logic [2*DATA_W-1:0] prod;
  a_wide = (op == MULH || op == MULHSU) ? {{DATA_W{a[DATA_W-1]}}, a} : {{DATA_W{1'b0}}, a};
  b_wide = (op == MULH) ? {{DATA_W{b[DATA_W-1]}}, b} : {{DATA_W{1'b0}}, b};
  prod   = a_wide * b_wide;
  // Low half for MUL, upper half for the rest
  return (op == MUL) ? prod[DATA_W-1:0] : prod[2*DATA_W-1:DATA_W];
endfunction

`endif

// ==== tb/tb_ex_stage.sv ====
module tb_ex_stage import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned DATA_W         = DATA_W_DEF;
  localparam int unsigned REG_ADDR_W     = REG_ADDR_W_DEF;
  localparam int          CLK_HALF       = 20;
  // Outputs sampled halfway through the low phase
  localparam int          CHECK_DELAY    = 10;
  localparam int          RESET_CYCLES   = 8;
  localparam int          NUM_OPS        = 400;
  // Reset plus 400 ops of at most 3 cycles each, with headroom
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] LFSR_SEED      = 32'hcd859eba;

  logic                  clk = 1'b0;
  logic                  rst_n;
  alu_op_e               alu_operator_i;
  logic [DATA_W-1:0]     alu_operand_a_i;
  logic [DATA_W-1:0]     alu_operand_b_i;
  logic [DATA_W-1:0]     alu_operand_c_i;
  logic                  alu_en_i;
  mult_op_e              mult_operator_i;
  logic [DATA_W-1:0]     mult_operand_a_i;
  logic [DATA_W-1:0]     mult_operand_b_i;
  logic                  mult_en_i;
  logic                  mult_multicycle_o;
  logic                  csr_access_i;
  logic [DATA_W-1:0]     csr_rdata_i;
  logic                  lsu_en_i;
  logic [DATA_W-1:0]     lsu_rdata_i;
  logic                  regfile_alu_we_i;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                  regfile_we_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_i;
  logic                  lsu_ready_ex_i;
  logic                  lsu_err_i;
  logic                  branch_in_ex_i;
  logic                  wb_ready_i;
  logic                  regfile_alu_we_fw_o;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [DATA_W-1:0]     regfile_alu_wdata_fw_o;
  logic                  regfile_we_wb_o;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic [DATA_W-1:0]     regfile_wdata_wb_o;
  logic                  branch_decision_o;
  logic [DATA_W-1:0]     jump_target_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;

  logic [31:0]           lfsr = LFSR_SEED;
  int                    cycle_cnt = 0;
  int                    checks = 0;
  int                    errors = 0;

  // Model state, multiplier high phase and EX/WB slot
  logic                  m_high = 1'b0;
  logic [DATA_W-1:0]     m_high_val = '0;
  logic                  exp_we_wb = 1'b0;
  logic [REG_ADDR_W-1:0] exp_waddr_wb = '0;
  logic                  exp_ready;
  logic                  exp_valid;

  `include "ex_ref_model.svh"

  ex_stage #(
    .DATA_W     (DATA_W),
    .REG_ADDR_W (REG_ADDR_W)
  ) dut0 (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (alu_operator_i),
    .alu_operand_a_i        (alu_operand_a_i),
    .alu_operand_b_i        (alu_operand_b_i),
    .alu_operand_c_i        (alu_operand_c_i),
    .alu_en_i               (alu_en_i),
    .mult_operator_i        (mult_operator_i),
    .mult_operand_a_i       (mult_operand_a_i),
    .mult_operand_b_i       (mult_operand_b_i),
    .mult_en_i              (mult_en_i),
    .mult_multicycle_o      (mult_multicycle_o),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .branch_decision_o      (branch_decision_o),
    .jump_target_o          (jump_target_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  always #CLK_HALF clk = ~clk;

  //////////////////////////////////////////////////
  // Random source and compare
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [DATA_W-1:0] exp_val,
                             input logic [DATA_W-1:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("Fail %0t: %s expected %h got %h", $time, what, exp_val, act_val);
    end
  endtask

  //////////////////////////////////////////////////
  // Expected outputs and model update
  //////////////////////////////////////////////////

  task automatic check_outputs();
    logic              m_ready;
    logic              units_ready;
    logic [DATA_W-1:0] exp_data;
    // Multiplier stalls only in the first cycle of a high-half op
    m_ready     = !(mult_en_i && (mult_operator_i != MUL) && !m_high);
    units_ready = m_ready && lsu_ready_ex_i && wb_ready_i;
    exp_ready   = units_ready || branch_in_ex_i;
    exp_valid   = units_ready && (alu_en_i || mult_en_i || csr_access_i || lsu_en_i);
    if (csr_access_i) begin
      exp_data = csr_rdata_i;
    end else if (mult_en_i) begin
      exp_data = m_high ? m_high_val : mult_ref(MUL, mult_operand_a_i, mult_operand_b_i);
    end else if (alu_en_i) begin
      exp_data = alu_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    end else begin
      exp_data = '0;
    end
    // Data of a high-half op is open while the product is captured
    if (csr_access_i || !mult_en_i || m_ready) begin
      check_value("forwarding data", exp_data, regfile_alu_wdata_fw_o);
    end
    check_value("forwarding we", regfile_alu_we_i, regfile_alu_we_fw_o);
    check_value("forwarding waddr", regfile_alu_waddr_i, regfile_alu_waddr_fw_o);
    if (alu_operator_i inside {EQ, NE, LT, GE, LTU, GEU}) begin
      check_value("branch decision", cmp_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                  branch_decision_o);
    end
    check_value("jump target", alu_operand_c_i, jump_target_o);
    check_value("ex_ready", exp_ready, ex_ready_o);
    check_value("ex_valid", exp_valid, ex_valid_o);
    check_value("mult multicycle", m_high, mult_multicycle_o);
    check_value("wb write enable", exp_we_wb, regfile_we_wb_o);
    check_value("wb write address", exp_waddr_wb, regfile_waddr_wb_o);
    check_value("wb write data", lsu_rdata_i, regfile_wdata_wb_o);
  endtask

  // Applies the rising edge to the model
  task automatic update_model();
    if (exp_valid) begin
      exp_we_wb = regfile_we_i && !lsu_err_i;
      if (exp_we_wb) begin
        exp_waddr_wb = regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      exp_we_wb = 1'b0;
    end
    if (!m_high && mult_en_i && (mult_operator_i != MUL)) begin
      m_high     = 1'b1;
      m_high_val = mult_ref(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
    end else if (m_high && exp_ready) begin
      m_high = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Driver
  //////////////////////////////////////////////////

  // One operation, held from a falling edge until the stage accepts it
  task automatic run_op();
    logic [2:0] kind;
    logic       accepted;
    int         stall_left;
    kind                = 3'(rand_bits(3));
    stall_left          = int'(rand_bits(1));
    alu_operator_i      = alu_op_e'(4'(rand_bits(4)));
    alu_operand_a_i     = rand_bits(DATA_W);
    alu_operand_b_i     = rand_bits(DATA_W);
    alu_operand_c_i     = rand_bits(DATA_W);
    mult_operator_i     = mult_op_e'(2'(rand_bits(2)));
    mult_operand_a_i    = rand_bits(DATA_W);
    mult_operand_b_i    = rand_bits(DATA_W);
    csr_rdata_i         = rand_bits(DATA_W);
    lsu_rdata_i         = rand_bits(DATA_W);
    regfile_alu_we_i    = rand_bit();
    regfile_alu_waddr_i = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    regfile_we_i        = rand_bit();
    regfile_waddr_i     = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    lsu_err_i           = (rand_bits(2) == 0);
    lsu_en_i            = rand_bit();
    alu_en_i            = 1'b0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    case (kind)
      3'd0, 3'd1: alu_en_i = 1'b1;
      3'd2: begin
        // Branch compares, equal operands now and then
        alu_en_i       = 1'b1;
        alu_operator_i = alu_op_e'(4'(10 + rand_bits(3) % 6));
        if (rand_bit()) begin
          alu_operand_b_i = alu_operand_a_i;
        end
      end
      3'd3: begin
        mult_en_i       = 1'b1;
        mult_operator_i = MUL;
      end
      3'd4: begin
        mult_en_i       = 1'b1;
        mult_operator_i = mult_op_e'(2'(1 + rand_bits(2) % 3));
      end
      3'd5, 3'd6: begin
        alu_en_i     = rand_bit();
        mult_en_i    = rand_bit();
        csr_access_i = rand_bit();
      end
      default: lsu_en_i = 1'b0;
    endcase
    branch_in_ex_i = (rand_bits(2) == 0) && !mult_en_i;
    accepted       = 1'b0;
    while (!accepted) begin
      // Back-pressure from write-back or the LSU, never in a multiplier stall
      if (stall_left > 0 && !(mult_en_i && mult_operator_i != MUL && !m_high)) begin
        stall_left--;
        wb_ready_i     = rand_bit();
        lsu_ready_ex_i = !wb_ready_i;
      end else begin
        wb_ready_i     = 1'b1;
        lsu_ready_ex_i = 1'b1;
      end
      #CHECK_DELAY;
      check_outputs();
      accepted = ex_ready_o;
      @(posedge clk);
      update_model();
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rst_n               = 1'b0;
    alu_operator_i      = ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    wb_ready_i          = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value("wb write enable in reset", '0, regfile_we_wb_o);
    check_value("wb write address in reset", '0, regfile_waddr_wb_o);
    check_value("mult multicycle in reset", '0, mult_multicycle_o);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_OPS; i++) begin
      run_op();
    end
    // Idle cycle to see the last EX/WB update
    alu_en_i       = 1'b0;
    mult_en_i      = 1'b0;
    csr_access_i   = 1'b0;
    lsu_en_i       = 1'b0;
    branch_in_ex_i = 1'b0;
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b1;
    #CHECK_DELAY;
    check_outputs();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hdl/ex_stage.sv ====
module ex_stage import ex_pkg::*; #(
  parameter int unsigned DATA_W     = DATA_W_DEF,
  parameter int unsigned REG_ADDR_W = REG_ADDR_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // ALU operands from decode
  input  alu_op_e               alu_operator_i,
  input  logic [DATA_W-1:0]     alu_operand_a_i,
  input  logic [DATA_W-1:0]     alu_operand_b_i,
  input  logic [DATA_W-1:0]     alu_operand_c_i,
  input  logic                  alu_en_i,
  // Multiplier operands from decode
  input  mult_op_e              mult_operator_i,
  input  logic [DATA_W-1:0]     mult_operand_a_i,
  input  logic [DATA_W-1:0]     mult_operand_b_i,
  input  logic                  mult_en_i,
  output logic                  mult_multicycle_o,
  // CSR and load/store
  input  logic                  csr_access_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  input  logic                  lsu_en_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  // Register file requests
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  // Stall control
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  // Forwarding port
  output logic                  regfile_alu_we_fw_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // Load write port
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  // Branch resolution to fetch
  output logic                  branch_decision_o,
  output logic [DATA_W-1:0]     jump_target_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp_result;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;

  // Branch target is computed in decode and only passes through
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu #(
    .DATA_W (DATA_W)
  ) alu0 (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Stage ready tells the multiplier its high half was taken
  ex_mult #(
    .DATA_W (DATA_W)
  ) mult0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback #(
    .DATA_W     (DATA_W),
    .REG_ADDR_W (REG_ADDR_W)
  ) wb0 (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// ==== hdl/ex_writeback.sv ====
module ex_writeback import ex_pkg::*; #(
  parameter int unsigned DATA_W     = DATA_W_DEF,
  parameter int unsigned REG_ADDR_W = REG_ADDR_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Unit enables
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic                  lsu_en_i,
  // Result sources
  input  logic [DATA_W-1:0]     alu_result_i,
  input  logic [DATA_W-1:0]     mult_result_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  input  logic                  mult_ready_i,
  // ALU write port request
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  // Load write port request
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  // Stall control
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  // Forwarding port
  output logic                  regfile_alu_we_fw_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // Load write port
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic units_ready;
  logic any_en;
  logic lsu_we;

  //////////////////////////////////////////////////
  // Forwarding write port
  //////////////////////////////////////////////////

  // CSR wins over the multiplier, the multiplier over the ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  // A bus error on the load cancels the write
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= lsu_we;
      if (lsu_we) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrives, flush the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data comes back in the write-back cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Stage handshake
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve here and never wait for write-back
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = any_en & units_ready;

endmodule

// ==== hdl/ex_mult.sv ====
module ex_mult import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_op_e          operator_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  // Second state presents the registered high half
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  logic                     signed_a;
  logic                     signed_b;
  logic [DATA_W:0]          op_a_ext;
  logic [DATA_W:0]          op_b_ext;
  logic signed [2*DATA_W+1:0] product;
  logic [DATA_W-1:0]        high_q;
  logic                     high_op;
  logic                     load_high;

  //////////////////////////////////////////////////
  // Operand extension and product
  //////////////////////////////////////////////////

  // MULH signs both, MULHSU only a, MULHU neither
  assign signed_a = (operator_i == MULH) || (operator_i == MULHSU);
  assign signed_b = (operator_i == MULH);

  assign op_a_ext = {signed_a & op_a_i[DATA_W-1], op_a_i};
  assign op_b_ext = {signed_b & op_b_i[DATA_W-1], op_b_i};

  // Signed multiply of the extended operands covers all sign modes
  assign product  = $signed(op_a_ext) * $signed(op_b_ext);

  assign high_op  = (operator_i != MUL);

  //////////////////////////////////////////////////
  // Two-cycle control
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    load_high    = 1'b0;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    // Low half straight from the multiplier
    result_o     = product[DATA_W-1:0];
    case (state_q)
      MULT_IDLE: begin
        if (enable_i && high_op) begin
          // Stall for one cycle while the product is captured
          ready_o   = 1'b0;
          load_high = 1'b1;
          state_d   = MULT_HIGH;
        end
      end
      MULT_HIGH: begin
        multicycle_o = 1'b1;
        result_o     = high_q;
        // Hold the result until the stage moves on
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: begin
        state_d = MULT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper half of the product for the second cycle
  always_ff @(posedge clk) begin
    if (load_high) begin
      high_q <= product[2*DATA_W-1:DATA_W];
    end
  end

endmodule

// ==== hdl/ex_alu.sv ====
module ex_alu import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEF
) (
  input  alu_op_e           operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);

  // Shift amount width from the word width
  localparam int unsigned SHAMT_W = $clog2(DATA_W);

  logic              adder_sub;
  logic              cmp_signed;
  logic [DATA_W:0]   adder_op_a;
  logic [DATA_W:0]   adder_op_b;
  logic [DATA_W:0]   adder_sum;
  logic              is_less;
  logic              is_equal;
  logic [DATA_W-1:0] xor_result;

  logic              shift_left;
  logic              shift_arith;
  logic [SHAMT_W-1:0] shift_amt;
  logic [DATA_W-1:0] operand_a_rev;
  logic [DATA_W-1:0] shift_in;
  logic [DATA_W:0]   shift_ext;
  logic [DATA_W-1:0] shift_right_result;
  logic [DATA_W-1:0] shift_right_rev;
  logic [DATA_W-1:0] shift_result;

  logic              cmp_result;

  //////////////////////////////////////////////////
  // Adder and comparator
  //////////////////////////////////////////////////

  // Everything except ADD subtracts
  assign adder_sub  = (operator_i != ADD);

  // Signed compares extend by the sign bit, unsigned by zero
  assign cmp_signed = (operator_i == SLT) || (operator_i == LT) || (operator_i == GE);

  // One extra bit so that the top bit of a - b is the less-than flag
  assign adder_op_a = {cmp_signed & operand_a_i[DATA_W-1], operand_a_i};
  assign adder_op_b = adder_sub ?
                      ~{cmp_signed & operand_b_i[DATA_W-1], operand_b_i} :
                      {cmp_signed & operand_b_i[DATA_W-1], operand_b_i};

  // Carry in of one completes the two's complement of operand b
  assign adder_sum  = adder_op_a + adder_op_b + {{DATA_W{1'b0}}, adder_sub};

  assign is_less    = adder_sum[DATA_W];

  // XOR result doubles as the equality check
  assign xor_result = operand_a_i ^ operand_b_i;
  assign is_equal   = (xor_result == '0);

  // Branch decision, also feeds the set-less-than results
  always_comb begin
    case (operator_i)
      EQ:                  cmp_result = is_equal;
      NE:                  cmp_result = ~is_equal;
      SLT, SLTU, LT, LTU:  cmp_result = is_less;
      GE, GEU:             cmp_result = ~is_less;
      default:             cmp_result = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp_result;

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  assign shift_left  = (operator_i == SLL);
  assign shift_arith = (operator_i == SRA);
  assign shift_amt   = operand_b_i[SHAMT_W-1:0];

  // Bit reversal of operand a for left shifts
  for (genvar i = 0; i < DATA_W; i++) begin : gen_rev_a
    assign operand_a_rev[i] = operand_a_i[DATA_W-1-i];
  end

  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // Fill bit is the sign only for arithmetic right shifts
  assign shift_ext = $signed({shift_arith & operand_a_i[DATA_W-1], shift_in}) >>> shift_amt;
  assign shift_right_result = shift_ext[DATA_W-1:0];

  // Reverse back to get the left shift
  for (genvar i = 0; i < DATA_W; i++) begin : gen_rev_res
    assign shift_right_rev[i] = shift_right_result[DATA_W-1-i];
  end

  assign shift_result = shift_left ? shift_right_rev : shift_right_result;

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ADD, SUB:      result_o = adder_sum[DATA_W-1:0];
      XOR:           result_o = xor_result;
      OR:            result_o = operand_a_i | operand_b_i;
      AND:           result_o = operand_a_i & operand_b_i;
      SLL, SRL, SRA: result_o = shift_result;
      // Comparisons give the decision zero-extended
      default:       result_o = {{(DATA_W-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

// ==== hdl/ex_pkg.sv ====
package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Default data word width of the stage
  localparam int unsigned DATA_W_DEF = 32;

  // Default register file address width
  localparam int unsigned REG_ADDR_W_DEF = 5;

  //////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////

  // ALU operations, arithmetic and logic first, comparisons last
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    XOR  = 4'd2,
    OR   = 4'd3,
    AND  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    // Branch comparisons
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // Multiplier operations
  // MUL gives the low half, the others the high half
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

endpackage
